// File: hdl/stap_bscan.sv
/*
  Boundary-scan chain and the one-bit RUNBIST register.
  Parallel outputs clear only on rst_n and not on TAP reset.
  Chain length comes from BSCAN_LEN.
*/
`timescale 1ns/100ps
`default_nettype none

module stap_bscan
(
   input  logic             ftap_tck,
   input  logic             rst_n,
   stap_dr_if.dst           dr,
   input  stap_pkg::bscan_t bscan_in,
   output stap_pkg::bscan_t bscan_out,
   output logic             runbist_en,
   output logic             bscan_lsb,
   output logic             runbist_bit
);

   stap_pkg::bscan_t chain;
   logic             runbist_sr;
   logic             bscan_sel;
   logic             runbist_sel;

   assign bscan_sel   = dr.dr_sel[stap_pkg::SEL_BSCAN];
   assign runbist_sel = dr.dr_sel[stap_pkg::SEL_RUNBIST];

   // ------------------------------
   // Shift stages
   // ------------------------------
   always_ff @(posedge ftap_tck)
   begin
      if (bscan_sel && dr.capture_dr)
         chain <= bscan_in;
      else if (bscan_sel && dr.shift_dr)
         chain <= {dr.tdi, chain[stap_pkg::BSCAN_LEN-1:1]};

      // RUNBIST bit always captures 0
      if (runbist_sel && dr.capture_dr)
         runbist_sr <= 1'b0;
      else if (runbist_sel && dr.shift_dr)
         runbist_sr <= dr.tdi;
   end

   // ------------------------------
   // Update stages
   // ------------------------------
   always_ff @(posedge ftap_tck)
   begin
      if (!rst_n)
      begin
         bscan_out  <= '0;
         runbist_en <= 1'b0;
      end
      else if (dr.update_dr)
      begin
         if (bscan_sel)
            bscan_out <= chain;
         if (runbist_sel)
            runbist_en <= runbist_sr;
      end
   end

   // Serial outputs toward the TDO mux
   assign bscan_lsb   = chain[0];
   assign runbist_bit = runbist_sr;

endmodule

`default_nettype wire

// File: hdl/stap_dr_if.sv
/*
  DR strobes, tdi and one-hot DR select.
  Strobes are plain levels, one per TAP state.
  No handshake since the TAP never stalls.
*/
`timescale 1ns/100ps
`default_nettype none

interface stap_dr_if;

   // Levels that follow capture_dr, shift_dr and update_dr states
   logic              capture_dr;
   logic              shift_dr;
   logic              update_dr;
   // Serial data into every DR
   logic              tdi;
   // Exactly one bit set from the current instruction
   stap_pkg::dr_sel_t dr_sel;

   // Instruction stage drives
   modport src (output capture_dr, shift_dr, update_dr, tdi, dr_sel);

   // Data registers and TDO mux listen
   modport dst (input capture_dr, shift_dr, update_dr, tdi, dr_sel);

endinterface

`default_nettype wire

// File: hdl/stap_fsm.sv
/*
  Sixteen-state JTAG TAP controller.
  rst_n is synchronous and forces test_logic_reset.
  Five tms ones reach test_logic_reset from any state.
*/
`timescale 1ns/100ps
`default_nettype none

module stap_fsm
(
   input  logic                 ftap_tck,
   input  logic                 rst_n,
   input  logic                 tms,
   output stap_pkg::tap_state_t state
);

   stap_pkg::tap_state_t state_nxt;

   // ------------------------------
   // Next state from tms
   // ------------------------------
   always_comb
   begin
      state_nxt = state;
      case (state)
         stap_pkg::test_logic_reset:
            state_nxt = tms ? stap_pkg::test_logic_reset : stap_pkg::run_test_idle;
         stap_pkg::run_test_idle:
            state_nxt = tms ? stap_pkg::select_dr_scan : stap_pkg::run_test_idle;
         // DR column
         stap_pkg::select_dr_scan:
            state_nxt = tms ? stap_pkg::select_ir_scan : stap_pkg::capture_dr;
         stap_pkg::capture_dr:
            state_nxt = tms ? stap_pkg::exit1_dr : stap_pkg::shift_dr;
         stap_pkg::shift_dr:
            state_nxt = tms ? stap_pkg::exit1_dr : stap_pkg::shift_dr;
         stap_pkg::exit1_dr:
            state_nxt = tms ? stap_pkg::update_dr : stap_pkg::pause_dr;
         stap_pkg::pause_dr:
            state_nxt = tms ? stap_pkg::exit2_dr : stap_pkg::pause_dr;
         stap_pkg::exit2_dr:
            state_nxt = tms ? stap_pkg::update_dr : stap_pkg::shift_dr;
         stap_pkg::update_dr:
            state_nxt = tms ? stap_pkg::select_dr_scan : stap_pkg::run_test_idle;
         // IR column
         stap_pkg::select_ir_scan:
            state_nxt = tms ? stap_pkg::test_logic_reset : stap_pkg::capture_ir;
         stap_pkg::capture_ir:
            state_nxt = tms ? stap_pkg::exit1_ir : stap_pkg::shift_ir;
         stap_pkg::shift_ir:
            state_nxt = tms ? stap_pkg::exit1_ir : stap_pkg::shift_ir;
         stap_pkg::exit1_ir:
            state_nxt = tms ? stap_pkg::update_ir : stap_pkg::pause_ir;
         stap_pkg::pause_ir:
            state_nxt = tms ? stap_pkg::exit2_ir : stap_pkg::pause_ir;
         stap_pkg::exit2_ir:
            state_nxt = tms ? stap_pkg::update_ir : stap_pkg::shift_ir;
         stap_pkg::update_ir:
            state_nxt = tms ? stap_pkg::select_dr_scan : stap_pkg::run_test_idle;
         default:
            state_nxt = stap_pkg::test_logic_reset;
      endcase
   end

   // ------------------------------
   // State register
   // ------------------------------
   always_ff @(posedge ftap_tck)
   begin
      if (!rst_n)
      begin
         state <= stap_pkg::test_logic_reset;
      end
      else
      begin
         state <= state_nxt;
      end
   end

endmodule

`default_nettype wire

// File: hdl/stap_ir.sv
/*
  IR shift register, instruction latch and decode.
  Capture loads 01. The instruction holds IR_IDCODE in test_logic_reset.
  DR strobes are decoded straight from the TAP state.
*/
`timescale 1ns/100ps
`default_nettype none

module stap_ir
(
   input  logic                 ftap_tck,
   input  logic                 rst_n,
   input  logic                 tdi,
   input  stap_pkg::tap_state_t state,
   output logic                 ir_lsb,
   stap_dr_if.src               dr
);

   stap_pkg::ir_t ir_shift;
   stap_pkg::ir_t ir_reg;

   // IR shift path
   always_ff @(posedge ftap_tck)
   begin
      if (state == stap_pkg::capture_ir)
      begin
         ir_shift <= stap_pkg::IR_CAPTURE;
      end
      else if (state == stap_pkg::shift_ir)
      begin
         // tdi enters at the top and bit 0 goes out on tdo
         ir_shift <= {tdi, ir_shift[3:1]};
      end
   end

   // Active instruction
   always_ff @(posedge ftap_tck)
   begin
      if (!rst_n || state == stap_pkg::test_logic_reset)
      begin
         ir_reg <= stap_pkg::IR_IDCODE;
      end
      else if (state == stap_pkg::update_ir)
      begin
         ir_reg <= ir_shift;
      end
   end

   assign ir_lsb = ir_shift[0];

   // One-hot DR select with unused codes falling back to BYPASS
   always_comb
   begin
      dr.dr_sel = '0;
      case (ir_reg)
         stap_pkg::IR_IDCODE:  dr.dr_sel[stap_pkg::SEL_IDCODE]  = 1'b1;
         stap_pkg::IR_BSCAN:   dr.dr_sel[stap_pkg::SEL_BSCAN]   = 1'b1;
         stap_pkg::IR_RUNBIST: dr.dr_sel[stap_pkg::SEL_RUNBIST] = 1'b1;
         stap_pkg::IR_RTDR0:   dr.dr_sel[stap_pkg::SEL_RTDR0]   = 1'b1;
         stap_pkg::IR_RTDR1:   dr.dr_sel[stap_pkg::SEL_RTDR1]   = 1'b1;
         default:              dr.dr_sel[stap_pkg::SEL_BYPASS]  = 1'b1;
      endcase
   end

   // DR strobes as levels
   assign dr.capture_dr = (state == stap_pkg::capture_dr);
   assign dr.shift_dr   = (state == stap_pkg::shift_dr);
   assign dr.update_dr  = (state == stap_pkg::update_dr);
   assign dr.tdi        = tdi;

endmodule

`default_nettype wire

// File: hdl/stap_pkg.sv
/*
  Shared types and constants for the TAP.
  IR is 4 bits wide. Unknown codes decode to BYPASS.
  Both DR lengths are fixed at 8 bits.
*/
`default_nettype none

package stap_pkg;

   // TAP controller states
   typedef enum logic [3:0]
   {
      test_logic_reset,
      run_test_idle,
      select_dr_scan,
      capture_dr,
      shift_dr,
      exit1_dr,
      pause_dr,
      exit2_dr,
      update_dr,
      select_ir_scan,
      capture_ir,
      shift_ir,
      exit1_ir,
      pause_ir,
      exit2_ir,
      update_ir
   } tap_state_t;

   // ------------------------------
   // Instruction register
   // ------------------------------
   typedef logic [3:0] ir_t;

   localparam ir_t IR_CAPTURE = 4'b0001;
   localparam ir_t IR_IDCODE  = 4'd1;
   localparam ir_t IR_BSCAN   = 4'd2;
   localparam ir_t IR_RUNBIST = 4'd3;
   localparam ir_t IR_RTDR0   = 4'd4;
   localparam ir_t IR_RTDR1   = 4'd5;
   localparam ir_t IR_BYPASS  = 4'd15;

   // ------------------------------
   // Data registers
   // ------------------------------
   localparam int BSCAN_LEN = 8;
   localparam int RTDR_LEN  = 8;

   typedef logic [31:0]          idcode_t;
   typedef logic [BSCAN_LEN-1:0] bscan_t;
   typedef logic [RTDR_LEN-1:0]  rtdr_t;

   // Bit 0 must stay 1 per 1149.1
   localparam idcode_t IDCODE_VALUE = 32'h1a57_c0df;

   // One-hot DR select and its bit positions
   typedef logic [5:0] dr_sel_t;

   localparam int SEL_IDCODE  = 0;
   localparam int SEL_BSCAN   = 1;
   localparam int SEL_RUNBIST = 2;
   localparam int SEL_RTDR0   = 3;
   localparam int SEL_RTDR1   = 4;
   localparam int SEL_BYPASS  = 5;

endpackage

`default_nettype wire

// File: hdl/stap_rtdr.sv
/*
  One remote test data register.
  Capture reads back the current parallel output as a loopback.
  SEL_BIT picks the dr_sel bit for this instance.
*/
`timescale 1ns/100ps
`default_nettype none

module stap_rtdr
#(
   parameter int SEL_BIT = stap_pkg::SEL_RTDR0
)
(
   input  logic            ftap_tck,
   input  logic            rst_n,
   stap_dr_if.dst          dr,
   output stap_pkg::rtdr_t rtdr_out,
   output logic            rtdr_lsb
);

   stap_pkg::rtdr_t rtdr_sr;
   logic            sel;

   // Only the instance named by the instruction reacts
   assign sel = dr.dr_sel[SEL_BIT];

   // ------------------------------
   // Shift register
   // ------------------------------
   always_ff @(posedge ftap_tck)
   begin
      if (sel && dr.capture_dr)
      begin
         // Loopback of the last updated value
         rtdr_sr <= rtdr_out;
      end
      else if (sel && dr.shift_dr)
      begin
         rtdr_sr <= {dr.tdi, rtdr_sr[stap_pkg::RTDR_LEN-1:1]};
      end
   end

   // Parallel output
   always_ff @(posedge ftap_tck)
   begin
      if (!rst_n)
      begin
         rtdr_out <= '0;
      end
      else if (sel && dr.update_dr)
      begin
         rtdr_out <= rtdr_sr;
      end
   end

   assign rtdr_lsb = rtdr_sr[0];

endmodule

`default_nettype wire

// File: hdl/stap_tdo_select.sv
/*
  BYPASS and IDCODE registers plus the TDO mux.
  tdo is combinational and 0 outside shift states.
  tdo_en is high only in shift_ir and shift_dr.
*/
`timescale 1ns/100ps
`default_nettype none

module stap_tdo_select
(
   input  logic                 ftap_tck,
   input  logic                 rst_n,
   input  stap_pkg::tap_state_t state,
   stap_dr_if.dst               dr,
   input  logic                 ir_lsb,
   input  logic                 bscan_lsb,
   input  logic                 runbist_bit,
   input  logic                 rtdr0_lsb,
   input  logic                 rtdr1_lsb,
   output logic                 tdo,
   output logic                 tdo_en
);

   logic              bypass_reg;
   stap_pkg::idcode_t idcode_sr;

   // ------------------------------
   // Local DRs
   // ------------------------------
   always_ff @(posedge ftap_tck)
   begin
      if (!rst_n)
      begin
         bypass_reg <= 1'b0;
         idcode_sr  <= stap_pkg::IDCODE_VALUE;
      end
      else
      begin
         // BYPASS captures 0 so scans out a leading 0
         if (dr.dr_sel[stap_pkg::SEL_BYPASS] && dr.capture_dr)
            bypass_reg <= 1'b0;
         else if (dr.dr_sel[stap_pkg::SEL_BYPASS] && dr.shift_dr)
            bypass_reg <= dr.tdi;

         if (dr.dr_sel[stap_pkg::SEL_IDCODE] && dr.capture_dr)
            idcode_sr <= stap_pkg::IDCODE_VALUE;
         else if (dr.dr_sel[stap_pkg::SEL_IDCODE] && dr.shift_dr)
            idcode_sr <= {dr.tdi, idcode_sr[31:1]};
      end
   end

   // TDO source from state and one-hot select
   always_comb
   begin
      tdo = 1'b0;
      if (state == stap_pkg::shift_ir)
         tdo = ir_lsb;
      else if (state == stap_pkg::shift_dr)
      begin
         case (1'b1)
            dr.dr_sel[stap_pkg::SEL_IDCODE]:  tdo = idcode_sr[0];
            dr.dr_sel[stap_pkg::SEL_BSCAN]:   tdo = bscan_lsb;
            dr.dr_sel[stap_pkg::SEL_RUNBIST]: tdo = runbist_bit;
            dr.dr_sel[stap_pkg::SEL_RTDR0]:   tdo = rtdr0_lsb;
            dr.dr_sel[stap_pkg::SEL_RTDR1]:   tdo = rtdr1_lsb;
            default:                          tdo = bypass_reg;
         endcase
      end
   end

   assign tdo_en = (state == stap_pkg::shift_ir) || (state == stap_pkg::shift_dr);

endmodule

`default_nettype wire

// File: hdl/stap_top.sv
/*
  TAP top level with plain ports.
  Pipeline of state, instruction, data registers and TDO select.
  Single clock ftap_tck with synchronous rst_n.
*/
`timescale 1ns/100ps
`default_nettype none

module stap_top
(
   input  logic             ftap_tck,
   input  logic             rst_n,
   input  logic             tms,
   input  logic             tdi,
   output logic             tdo,
   output logic             tdo_en,
   input  stap_pkg::bscan_t bscan_in,
   output stap_pkg::bscan_t bscan_out,
   output logic             runbist_en,
   output stap_pkg::rtdr_t  rtdr0_out,
   output stap_pkg::rtdr_t  rtdr1_out
);

   stap_pkg::tap_state_t state;
   logic                 ir_lsb;
   logic                 bscan_lsb;
   logic                 runbist_bit;
   logic                 rtdr0_lsb;
   logic                 rtdr1_lsb;

   // Strobes and select shared by all DRs
   stap_dr_if dr_bus ();

   // ------------------------------
   // Control stages
   // ------------------------------
   stap_fsm u_fsm
   (
      .ftap_tck (ftap_tck),
      .rst_n    (rst_n),
      .tms      (tms),
      .state    (state)
   );

   stap_ir u_ir
   (
      .ftap_tck (ftap_tck),
      .rst_n    (rst_n),
      .tdi      (tdi),
      .state    (state),
      .ir_lsb   (ir_lsb),
      .dr       (dr_bus.src)
   );

   // ------------------------------
   // Data registers
   // ------------------------------
   stap_bscan u_bscan
   (
      .ftap_tck    (ftap_tck),
      .rst_n       (rst_n),
      .dr          (dr_bus.dst),
      .bscan_in    (bscan_in),
      .bscan_out   (bscan_out),
      .runbist_en  (runbist_en),
      .bscan_lsb   (bscan_lsb),
      .runbist_bit (runbist_bit)
   );

   stap_rtdr #(.SEL_BIT(stap_pkg::SEL_RTDR0)) u_rtdr0
   (
      .ftap_tck (ftap_tck),
      .rst_n    (rst_n),
      .dr       (dr_bus.dst),
      .rtdr_out (rtdr0_out),
      .rtdr_lsb (rtdr0_lsb)
   );

   stap_rtdr #(.SEL_BIT(stap_pkg::SEL_RTDR1)) u_rtdr1
   (
      .ftap_tck (ftap_tck),
      .rst_n    (rst_n),
      .dr       (dr_bus.dst),
      .rtdr_out (rtdr1_out),
      .rtdr_lsb (rtdr1_lsb)
   );

   // Output mux plus BYPASS and IDCODE
   stap_tdo_select u_tdo_select
   (
      .ftap_tck    (ftap_tck),
      .rst_n       (rst_n),
      .state       (state),
      .dr          (dr_bus.dst),
      .ir_lsb      (ir_lsb),
      .bscan_lsb   (bscan_lsb),
      .runbist_bit (runbist_bit),
      .rtdr0_lsb   (rtdr0_lsb),
      .rtdr1_lsb   (rtdr1_lsb),
      .tdo         (tdo),
      .tdo_en      (tdo_en)
   );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the TAP testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
   --top-module stap_tb -o stap_sim -f sources.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/stap_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# The simulation log decides the result
if printf '%s\n' "$output" | grep -q "Simulation finished: PASS"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: sources.f
hdl/stap_pkg.sv
hdl/stap_dr_if.sv
hdl/stap_fsm.sv
hdl/stap_ir.sv
hdl/stap_bscan.sv
hdl/stap_rtdr.sv
hdl/stap_tdo_select.sv
hdl/stap_top.sv
tb/stap_tb.sv

// File: tb/stap_tb.sv
/*
  Self-checking testbench for stap_top driven by the rows of tb/stap_vectors.txt.
  Each row may run an IR scan and then one DR scan of 2 to 32 bits.
  Random rows assume the scan length equals the register length.
  The first failing check stops the run.
*/
`timescale 1ns/100ps
`default_nettype none

module stap_tb;

   localparam int CLK_PERIOD     = 40;
   localparam int RESET_CYCLES   = 5;
   localparam int SHIFT_WAIT     = 8;
   localparam int MODE_NORMAL    = 0;
   localparam int MODE_RANDOM    = 1;
   localparam int MODE_DR_ONLY   = 2;
   localparam int MODE_TMS_RESET = 3;

   logic             ftap_tck;
   logic             rst_n;
   logic             tms;
   logic             tdi;
   logic             tdo;
   logic             tdo_en;
   stap_pkg::bscan_t bscan_in;
   stap_pkg::bscan_t bscan_out;
   logic             runbist_en;
   stap_pkg::rtdr_t  rtdr0_out;
   stap_pkg::rtdr_t  rtdr1_out;

   // Expected parallel outputs
   stap_pkg::bscan_t m_bscan;
   logic             m_runbist;
   stap_pkg::rtdr_t  m_rtdr0;
   stap_pkg::rtdr_t  m_rtdr1;
   logic [31:0]      rng;

   // Fields of the current vector row
   int          row_mode;
   int          row_len;
   logic [31:0] row_ir, row_data, row_tdo, row_bscan_in;
   logic [31:0] row_bscan, row_runbist, row_rtdr0, row_rtdr1, row_mask;

   stap_top DUT
   (
      .ftap_tck   (ftap_tck),
      .rst_n      (rst_n),
      .tms        (tms),
      .tdi        (tdi),
      .tdo        (tdo),
      .tdo_en     (tdo_en),
      .bscan_in   (bscan_in),
      .bscan_out  (bscan_out),
      .runbist_en (runbist_en),
      .rtdr0_out  (rtdr0_out),
      .rtdr1_out  (rtdr1_out)
   );

   initial
   begin
      ftap_tck = 1'b0;
      forever
         #(CLK_PERIOD / 2) ftap_tck = ~ftap_tck;
   end

   // ------------------------------
   // Helpers
   // ------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      begin
         x = s;
         x = x ^ (x << 13);
         x = x ^ (x >> 17);
         x = x ^ (x << 5);
         return x;
      end
   endfunction

   function automatic logic [31:0] len_mask(input int len);
      begin
         if (len >= 32)
            return 32'hffff_ffff;
         return (32'd1 << len) - 32'd1;
      end
   endfunction

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic report_failure(input string why);
      $display("error at %0t: %s", $time, why);
      abort_run();
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected)
      begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
         abort_run();
      end
   endtask

   // One TCK cycle, tdo taken mid-cycle where it is stable
   task automatic clock_bit(input logic t, input logic d, output logic o);
      @(posedge ftap_tck);
      tms <= t;
      tdi <= d;
      @(negedge ftap_tck);
      o = tdo;
   endtask

   // Full scan from run_test_idle or test_logic_reset back to run_test_idle
   task automatic scan(input logic is_ir, input int len, input logic [31:0] data,
                       output logic [31:0] out);
      logic bit_out;
      int   waited;
      begin
         out = '0;
         clock_bit(1'b0, 1'b0, bit_out);
         clock_bit(1'b1, 1'b0, bit_out);
         if (is_ir)
            clock_bit(1'b1, 1'b0, bit_out);
         clock_bit(1'b0, 1'b0, bit_out);
         // Hold tms low through capture until tdo_en shows the shift state
         clock_bit(1'b0, data[0], bit_out);
         waited = 1;
         while (tdo_en !== 1'b1)
         begin
            if (waited >= SHIFT_WAIT)
               report_failure("TAP did not reach a shift state after capture");
            clock_bit(1'b0, data[0], bit_out);
            waited = waited + 1;
         end
         out[0] = bit_out;
         for (int i = 1; i < len; i++)
         begin
            clock_bit(i == len - 1, data[i], bit_out);
            check_value("tdo_en", 32'(tdo_en), 32'd1);
            out[i] = bit_out;
         end
         // exit1 then update
         clock_bit(1'b1, 1'b0, bit_out);
         check_value("tdo_en", 32'(tdo_en), 32'd0);
         clock_bit(1'b0, 1'b0, bit_out);
      end
   endtask

   task automatic reset_by_tms();
      logic bit_out;
      begin
         repeat (5)
            clock_bit(1'b1, 1'b0, bit_out);
         check_value("tdo_en", 32'(tdo_en), 32'd0);
      end
   endtask

   task automatic check_outputs();
      check_value("bscan_out", 32'(bscan_out), 32'(m_bscan));
      check_value("runbist_en", 32'(runbist_en), 32'(m_runbist));
      check_value("rtdr0_out", 32'(rtdr0_out), 32'(m_rtdr0));
      check_value("rtdr1_out", 32'(rtdr1_out), 32'(m_rtdr1));
   endtask

   // Expected scan-out and new outputs of a random row from the register rules
   task automatic predict_random(input logic [31:0] data, output logic [31:0] want);
      case (row_ir[3:0])
         stap_pkg::IR_IDCODE:
            want = stap_pkg::IDCODE_VALUE;
         stap_pkg::IR_BSCAN:
         begin
            want    = (data << stap_pkg::BSCAN_LEN) | row_bscan_in;
            m_bscan = stap_pkg::bscan_t'(data >> (row_len - stap_pkg::BSCAN_LEN));
         end
         stap_pkg::IR_RUNBIST:
         begin
            want      = data << 1;
            m_runbist = data[row_len - 1];
         end
         stap_pkg::IR_RTDR0:
         begin
            // Loopback returns the last updated value
            want    = (data << stap_pkg::RTDR_LEN) | 32'(m_rtdr0);
            m_rtdr0 = stap_pkg::rtdr_t'(data >> (row_len - stap_pkg::RTDR_LEN));
         end
         stap_pkg::IR_RTDR1:
         begin
            want    = (data << stap_pkg::RTDR_LEN) | 32'(m_rtdr1);
            m_rtdr1 = stap_pkg::rtdr_t'(data >> (row_len - stap_pkg::RTDR_LEN));
         end
         default:
            want = data << 1;
      endcase
      want = want & len_mask(row_len);
   endtask

   task automatic run_row();
      logic [31:0] ir_out;
      logic [31:0] dr_out;
      logic [31:0] data;
      logic [31:0] want_tdo;
      begin
         // Parallel input one cycle ahead of the scans
         @(posedge ftap_tck);
         bscan_in <= row_bscan_in[stap_pkg::BSCAN_LEN-1:0];
         @(negedge ftap_tck);
         data = row_data & len_mask(row_len);
         if (row_mode == MODE_RANDOM)
         begin
            rng  = xorshift32(rng);
            data = rng & len_mask(row_len);
         end
         if (row_mode == MODE_TMS_RESET)
            reset_by_tms();
         if (row_mode == MODE_NORMAL || row_mode == MODE_RANDOM)
         begin
            scan(1'b1, 4, {28'd0, row_ir[3:0]}, ir_out);
            // First two bits out are the capture pattern 01
            check_value("ir_capture", ir_out & 32'h3, 32'h1);
         end
         if (row_mode == MODE_RANDOM)
            predict_random(data, want_tdo);
         else
         begin
            want_tdo = row_tdo & len_mask(row_len);
            if (row_mask[1])
               m_bscan = row_bscan[stap_pkg::BSCAN_LEN-1:0];
            if (row_mask[2])
               m_runbist = row_runbist[0];
            if (row_mask[3])
               m_rtdr0 = row_rtdr0[stap_pkg::RTDR_LEN-1:0];
            if (row_mask[4])
               m_rtdr1 = row_rtdr1[stap_pkg::RTDR_LEN-1:0];
         end
         scan(1'b0, row_len, data, dr_out);
         // Let the update edge land
         clock_bit(1'b0, 1'b0, ir_out[0]);
         if (row_mode == MODE_RANDOM || row_mask[0])
            check_value("tdo", dr_out, want_tdo);
         check_outputs();
      end
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial
   begin
      string line;
      int    fd;
      int    r;
      int    rows;
      rst_n     = 1'b0;
      tms       = 1'b1;
      tdi       = 1'b0;
      bscan_in  = '0;
      rng       = 32'haeee_598b;
      m_bscan   = '0;
      m_runbist = 1'b0;
      m_rtdr0   = '0;
      m_rtdr1   = '0;
      rows      = 0;
      repeat (RESET_CYCLES) @(posedge ftap_tck);
      rst_n <= 1'b1;
      @(negedge ftap_tck);
      check_value("tdo_en", 32'(tdo_en), 32'd0);
      check_outputs();

      fd = $fopen("tb/stap_vectors.txt", "r");
      if (fd == 0)
         report_failure("cannot open tb/stap_vectors.txt");
      while ($fgets(line, fd) != 0)
      begin
         r = $sscanf(line, "%d %h %d %h %h %h %h %h %h %h %h", row_mode, row_ir, row_len,
                     row_data, row_tdo, row_bscan_in, row_bscan, row_runbist,
                     row_rtdr0, row_rtdr1, row_mask);
         // Comment and blank lines match nothing
         if (r > 0)
         begin
            if (r != 11)
               report_failure("a vector line has the wrong number of fields");
            if (row_mode != MODE_NORMAL && row_mode != MODE_RANDOM &&
                row_mode != MODE_DR_ONLY && row_mode != MODE_TMS_RESET)
               report_failure("a vector line has an unknown mode");
            if (row_len < 2 || row_len > 32)
               report_failure("a vector line has a DR length outside 2 to 32");
            run_row();
            rows = rows + 1;
         end
      end
      $fclose(fd);

      if (rows == 0)
      begin
         $display("error: the vector file held no rows");
         abort_run();
      end
      else
      begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: tb/stap_vectors.txt
# mode ir len tdi_data exp_tdo bscan_in exp_bscan exp_runbist exp_rtdr0 exp_rtdr1 mask
# mode 0 IR+DR scan, 1 random data, 2 DR scan only, 3 five tms ones then DR scan
# mask bit 0 checks exp_tdo, bits 1..4 give new bscan, runbist, rtdr0, rtdr1 values
# IDCODE straight after reset
2 1 32 00000000 1a57c0df 00 00 0 00 00 01
0 1 32 deadbeef 1a57c0df 00 00 0 00 00 01
# BYPASS and unused codes
0 f 8 a5 4a 00 00 0 00 00 01
0 9 8 3c 78 00 00 0 00 00 01
0 0 4 9 2 00 00 0 00 00 01
# Boundary scan capture and update
0 2 8 c3 5a 5a c3 0 00 00 03
0 2 8 0f e1 e1 0f 0 00 00 03
# Remote registers with loopback readback
1 4 8 0 0 00 00 0 00 00 00
1 5 8 0 0 00 00 0 00 00 00
1 4 8 0 0 00 00 0 00 00 00
1 5 8 0 0 00 00 0 00 00 00
# RUNBIST up, down, up
0 3 2 2 0 00 00 1 00 00 05
0 3 2 1 2 00 00 0 00 00 05
0 3 2 2 0 00 00 1 00 00 05
# TAP reset through tms keeps the data outputs
3 1 32 00000000 1a57c0df 00 00 0 00 00 01
1 4 8 0 0 00 00 0 00 00 00
0 2 8 81 3c 3c 81 0 00 00 03
1 f 8 0 0 00 00 0 00 00 00
1 1 32 0 0 00 00 0 00 00 00
